/* vlog.f */
+incdir+hdl
hdl/stream_test_pkg.sv
hdl/rand_delay.sv
hdl/test_source.sv
hdl/test_sink.sv
hdl/stream_test_top.sv
tb/stream_checker.sv
tb/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the stream test harness with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --timescale 1ns/100ps -f vlog.f --top-module tb_top \
  --Mdir obj_dir -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log

grep -qx "Simulation PASSED" sim.log && exit 0 || exit 1

/* tb/stream_tests.dat */
# One test per line: src_max_delay sink_max_delay num_msgs mutations
# Mutations invert the low bit of sink entries 0 .. mutations-1
0 0 16 0
1 1 16 0
2 2 24 0
10 10 32 0
3 10 32 0
10 3 32 0
0 0 16 3
4 6 20 1
0 0 12 0
2 5 64 64
1 1 40 0
0 7 8 8
7 0 64 0
3 10 48 2
10 3 48 0
255 255 1 0

/* tb/tb_top.sv */
// ----------------------------------------
// Testbench top for the stream test harness
// Reads tests from the data file, loads both memories and runs each test
// ----------------------------------------

`include "stream_test_macros.svh"

module tb_top
  import stream_test_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          DONE_TIMEOUT = 5000;
  localparam logic [31:0] RNG_SEED     = 32'h7db5_bafd;

  logic                clk;
  logic                rst_n;
  load_t               load;
  logic                start;
  logic [`IDX_W-1:0]   num_msgs;
  logic [`DELAY_W-1:0] src_max_delay;
  logic [`DELAY_W-1:0] sink_max_delay;
  logic                done;
  logic [`IDX_W-1:0]   err_count;
  logic [`IDX_W-1:0]   first_err_idx;

  // Expected results handed to the checker
  int                  test_id;
  logic [`IDX_W-1:0]   exp_err;
  logic [`IDX_W-1:0]   exp_first;

  int                  pass_count;
  int                  fail_count;
  int                  result_count;

  logic [31:0]         rng;
  int                  tests_run;
  logic                timed_out;

  // ----------------------------------------
  // DUT and checker
  // ----------------------------------------

  stream_test_top uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .load           (load),
    .start          (start),
    .num_msgs       (num_msgs),
    .src_max_delay  (src_max_delay),
    .sink_max_delay (sink_max_delay),
    .done           (done),
    .err_count      (err_count),
    .first_err_idx  (first_err_idx)
  );

  stream_checker u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (start),
    .num_msgs       (num_msgs),
    .src_max_delay  (src_max_delay),
    .sink_max_delay (sink_max_delay),
    .done           (done),
    .err_count      (err_count),
    .first_err_idx  (first_err_idx),
    .test_id        (test_id),
    .exp_err        (exp_err),
    .exp_first      (exp_first),
    .pass_count     (pass_count),
    .fail_count     (fail_count),
    .result_count   (result_count)
  );

  // 100 ns clock period
  always #50 clk = ~clk;

  // 32-bit xorshift step for message payloads
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // One write through the load port, sel picks source or sink memory
  task automatic write_mem(input logic sel, input int addr, input logic [`MSG_W-1:0] data);
    @(posedge clk);
    load.we   <= 1'b1;
    load.sel  <= sel;
    load.addr <= addr[`IDX_W-1:0];
    load.data <= data;
  endtask

  // ----------------------------------------
  // One test: load, start, wait for done
  // ----------------------------------------
  task automatic run_test(input int sd, input int kd, input int n, input int m);
    logic [`MSG_W-1:0] msgs [`MEM_DEPTH];
    logic [`MSG_W-1:0] exp_val;
    int                i;
    int                cycles;
    logic              got_done;

    for (i = 0; i < n; i++)
    begin
      rng     = xorshift32(rng);
      msgs[i] = rng[`MSG_W-1:0];
    end

    // Same payloads in both memories, first m sink entries get a flipped low bit
    for (i = 0; i < n; i++)
    begin
      write_mem(SEL_SRC, i, msgs[i]);
      exp_val = (i < m) ? (msgs[i] ^ 8'h01) : msgs[i];
      write_mem(SEL_SINK, i, exp_val);
    end

    @(posedge clk);
    load           <= '0;
    src_max_delay  <= sd[`DELAY_W-1:0];
    sink_max_delay <= kd[`DELAY_W-1:0];
    num_msgs       <= n[`IDX_W-1:0];
    test_id        <= tests_run;
    exp_err        <= m[`IDX_W-1:0];
    exp_first      <= (m > 0) ? '0 : '1;
    start          <= 1'b1;
    @(posedge clk);
    start <= 1'b0;

    // Done was cleared on this edge, poll it on falling edges
    cycles   = 0;
    got_done = 1'b0;
    while (!got_done && cycles < DONE_TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
      if (done)
        got_done = 1'b1;
    end

    if (!got_done)
    begin
      $display("Timeout: test %0d got no done within %0d cycles", tests_run, DONE_TIMEOUT);
      timed_out = 1'b1;
    end

    tests_run++;
    // Idle gap so the checker has logged the result
    repeat (3) @(posedge clk);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    int    fd;
    int    code;
    int    sd;
    int    kd;
    int    n;
    int    m;
    string line;

    clk            = 1'b0;
    rst_n          = 1'b0;
    load           = '0;
    start          = 1'b0;
    num_msgs       = '0;
    src_max_delay  = '0;
    sink_max_delay = '0;
    test_id        = 0;
    exp_err        = '0;
    exp_first      = '1;
    rng            = RNG_SEED;
    tests_run      = 0;
    timed_out      = 1'b0;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    fd = $fopen("tb/stream_tests.dat", "r");
    if (fd == 0)
      $display("Could not open the test data file tb/stream_tests.dat");
    else
    begin
      while (!timed_out && !$feof(fd))
      begin
        line = "";
        code = $fgets(line, fd);
        // Skip blank lines and lines starting with '#'
        if (code != 0 && line.len() > 0 && line.getc(0) != 8'h23)
        begin
          if ($sscanf(line, "%d %d %d %d", sd, kd, n, m) == 4)
            run_test(sd, kd, n, m);
        end
      end
      $fclose(fd);
    end

    if (timed_out)
      $display("Run stopped early after a timeout");
    if (result_count != tests_run)
      $display("Checker logged %0d results for %0d tests", result_count, tests_run);

    $display("Tests run %0d, passed %0d, failed %0d", tests_run, pass_count, fail_count);
    if (!timed_out && tests_run > 0 && fail_count == 0 && result_count == tests_run)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

/* tb/stream_checker.sv */
// ----------------------------------------
// Result checker for the stream test harness
// Watches the DUT ports and compares done results with expected values
// ----------------------------------------

`include "stream_test_macros.svh"

module stream_checker
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic [`IDX_W-1:0]   num_msgs,
  input  logic [`DELAY_W-1:0] src_max_delay,
  input  logic [`DELAY_W-1:0] sink_max_delay,
  input  logic                done,
  input  logic [`IDX_W-1:0]   err_count,
  input  logic [`IDX_W-1:0]   first_err_idx,
  input  int                  test_id,
  input  logic [`IDX_W-1:0]   exp_err,
  input  logic [`IDX_W-1:0]   exp_first,
  output int                  pass_count,
  output int                  fail_count,
  output int                  result_count
);

  timeunit 1ns;
  timeprecision 100ps;

  logic done_q;
  logic start_q;
  logic seen_done;
  logic test_bad;

  // Sample on the falling edge while DUT outputs are steady
  always @(negedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      done_q       = 1'b0;
      start_q      = 1'b0;
      seen_done    = 1'b0;
      test_bad     = 1'b0;
      pass_count   = 0;
      fail_count   = 0;
      result_count = 0;
    end
    else
    begin
      // ----------------------------------------
      // DUT took start on the last rising edge
      // ----------------------------------------
      if (start_q && num_msgs != '0)
      begin
        seen_done = 1'b0;
        test_bad  = 1'b0;
        // Done and counters must be back to their idle values
        if (done !== 1'b0 || err_count !== '0 || first_err_idx !== '1)
        begin
          $display("CHECK FAILED at %0t: test %0d start left done %0b err_count %0d idx %0d",
                   $time, test_id, done, err_count, first_err_idx);
          test_bad = 1'b1;
        end
      end

      // ----------------------------------------
      // Done rising ends a test
      // ----------------------------------------
      if (done && !done_q)
      begin
        // A second rise without a start means a duplicated or lost message
        if (seen_done)
        begin
          $display("CHECK FAILED at %0t: test %0d done rose twice", $time, test_id);
          test_bad = 1'b1;
        end
        seen_done = 1'b1;

        if (err_count !== exp_err)
        begin
          $display("CHECK FAILED at %0t: test %0d err_count %0d, expected %0d",
                   $time, test_id, err_count, exp_err);
          test_bad = 1'b1;
        end
        if (first_err_idx !== exp_first)
        begin
          $display("CHECK FAILED at %0t: test %0d first_err_idx %0d, expected %0d",
                   $time, test_id, first_err_idx, exp_first);
          test_bad = 1'b1;
        end

        if (test_bad)
          fail_count++;
        else
          pass_count++;
        result_count++;

        $display("test %0d: delays %0d/%0d, %0d msgs, err_count %0d, first_err_idx %0d, %s",
                 test_id, src_max_delay, sink_max_delay, num_msgs, err_count,
                 first_err_idx, test_bad ? "FAIL" : "ok");
      end

      done_q  = done;
      start_q = start;
    end
  end

endmodule

/* hdl/stream_test_top.sv */
// ----------------------------------------
// Stream test harness top, source -> two random delays -> sink
// Load both memories, set the delays, pulse start and wait for done
// ----------------------------------------

`include "stream_test_macros.svh"

module stream_test_top
  import stream_test_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  load_t               load,
  input  logic                start,
  input  logic [`IDX_W-1:0]   num_msgs,
  input  logic [`DELAY_W-1:0] src_max_delay,
  input  logic [`DELAY_W-1:0] sink_max_delay,
  output logic                done,
  output logic [`IDX_W-1:0]   err_count,
  output logic [`IDX_W-1:0]   first_err_idx
);

  // Links along the chain, each with its ready going upstream
  stream_t src_s;
  logic    src_rdy;
  stream_t mid_s;
  logic    mid_rdy;
  stream_t snk_s;
  logic    snk_rdy;

  test_source u_src (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (load),
    .start    (start),
    .num_msgs (num_msgs),
    .out_s    (src_s),
    .out_rdy  (src_rdy)
  );

  // Different seeds so the two stages stall independently
  rand_delay #(.SEED(16'hace1)) u_src_dly (
    .clk       (clk),
    .rst_n     (rst_n),
    .max_delay (src_max_delay),
    .in_s      (src_s),
    .in_rdy    (src_rdy),
    .out_s     (mid_s),
    .out_rdy   (mid_rdy)
  );

  rand_delay #(.SEED(16'h3b5d)) u_sink_dly (
    .clk       (clk),
    .rst_n     (rst_n),
    .max_delay (sink_max_delay),
    .in_s      (mid_s),
    .in_rdy    (mid_rdy),
    .out_s     (snk_s),
    .out_rdy   (snk_rdy)
  );

  test_sink u_sink (
    .clk           (clk),
    .rst_n         (rst_n),
    .load          (load),
    .start         (start),
    .num_msgs      (num_msgs),
    .in_s          (snk_s),
    .in_rdy        (snk_rdy),
    .done          (done),
    .err_count     (err_count),
    .first_err_idx (first_err_idx)
  );

endmodule

/* hdl/test_sink.sv */
// ----------------------------------------
// Test sink, checks every arriving message against the expected memory
// Loaded with sel = 1, reports the error count and first bad index at done
// ----------------------------------------

`include "stream_test_macros.svh"

module test_sink
  import stream_test_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  load_t             load,
  input  logic              start,
  input  logic [`IDX_W-1:0] num_msgs,
  input  stream_t           in_s,
  output logic              in_rdy,
  output logic              done,
  output logic [`IDX_W-1:0] err_count,
  output logic [`IDX_W-1:0] first_err_idx
);

  localparam int AW = $clog2(`MEM_DEPTH);

  logic [`MSG_W-1:0] exp_mem [`MEM_DEPTH];

  logic              running;
  logic [`IDX_W-1:0] rx_idx;
  logic              wr_en;
  logic              xfer;
  logic              mismatch;
  logic              last;

  // ----------------------------------------
  // Expected-value memory
  // ----------------------------------------

  assign wr_en = load.we && (load.sel == SEL_SINK) && (load.addr < `MEM_DEPTH);

  always_ff @(posedge clk)
  begin
    if (wr_en)
      exp_mem[load.addr[AW-1:0]] <= load.data;
  end

  // ----------------------------------------
  // Receive and compare
  // ----------------------------------------

  // Always ready while a test runs
  assign in_rdy = running;

  assign xfer     = running && in_s.val;
  assign mismatch = (in_s.msg != exp_mem[rx_idx[AW-1:0]]);
  assign last     = (rx_idx == num_msgs - 1'b1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      running       <= 1'b0;
      rx_idx        <= '0;
      done          <= 1'b0;
      err_count     <= '0;
      first_err_idx <= '0;
    end
    else if (start)
    begin
      // New test, all ones marks "no mismatch yet"
      running       <= (num_msgs != '0);
      rx_idx        <= '0;
      done          <= (num_msgs == '0);
      err_count     <= '0;
      first_err_idx <= '1;
    end
    else if (xfer)
    begin
      rx_idx <= rx_idx + 1'b1;

      if (mismatch)
      begin
        err_count <= err_count + 1'b1;
        // Keep only the earliest bad index
        if (err_count == '0)
          first_err_idx <= rx_idx;
      end

      // Done shows up the cycle after the last reception
      if (last)
      begin
        running <= 1'b0;
        done    <= 1'b1;
      end
    end
  end

endmodule

/* hdl/test_source.sv */
// ----------------------------------------
// Test source memory, replays loaded messages in order after start
// Loaded through the load port with sel = 0 while idle
// ----------------------------------------

`include "stream_test_macros.svh"

module test_source
  import stream_test_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  load_t             load,
  input  logic              start,
  input  logic [`IDX_W-1:0] num_msgs,
  output stream_t           out_s,
  input  logic              out_rdy
);

  localparam int AW = $clog2(`MEM_DEPTH);

  logic [`MSG_W-1:0] mem [`MEM_DEPTH];

  logic              running;
  logic [`IDX_W-1:0] rd_idx;
  logic              wr_en;
  logic              xfer;
  logic              last;

  // ----------------------------------------
  // Message memory
  // ----------------------------------------

  // Ignore writes aimed past the end of the memory
  assign wr_en = load.we && (load.sel == SEL_SRC) && (load.addr < `MEM_DEPTH);

  // Payload storage, no reset
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[load.addr[AW-1:0]] <= load.data;
  end

  // ----------------------------------------
  // Replay
  // ----------------------------------------

  // Current entry is offered for as long as we run
  assign out_s.val = running;
  assign out_s.msg = mem[rd_idx[AW-1:0]];

  assign xfer = running && out_rdy;
  assign last = (rd_idx == num_msgs - 1'b1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      running <= 1'b0;
      rd_idx  <= '0;
    end
    else if (start)
    begin
      // Val rises the cycle after start, nothing to send for a zero count
      running <= (num_msgs != '0);
      rd_idx  <= '0;
    end
    else if (xfer)
    begin
      rd_idx <= rd_idx + 1'b1;
      // Drop val once the final message has been taken
      if (last)
        running <= 1'b0;
    end
  end

endmodule

/* hdl/rand_delay.sv */
// ----------------------------------------
// Valid/ready stage that stalls each message a random number of cycles
// A zero maximum delay makes it a plain combinational pass-through
// ----------------------------------------

`include "stream_test_macros.svh"

module rand_delay
  import stream_test_pkg::*;
#(
  parameter logic [15:0] SEED = 16'hace1
)(
  input  logic               clk,
  input  logic               rst_n,
  input  logic [`DELAY_W-1:0] max_delay,
  input  stream_t            in_s,
  output logic               in_rdy,
  output stream_t            out_s,
  input  logic               out_rdy
);

  // Galois feedback for x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [15:0] LFSR_TAPS = 16'hb400;

  logic [15:0]          lfsr;
  logic [`DELAY_W-1:0]  cnt;
  logic                 armed;

  logic [`DELAY_W:0]    range;
  logic [15:0]          lfsr_mod;
  logic [`DELAY_W-1:0]  draw;
  logic                 arriving;
  logic                 stall;
  logic                 xfer;

  // ----------------------------------------
  // Delay draw
  // ----------------------------------------

  // Uniform over 0 .. max_delay, extra bit keeps 255+1 from wrapping
  assign range    = {1'b0, max_delay} + 1'b1;
  assign lfsr_mod = lfsr % range;
  assign draw     = lfsr_mod[`DELAY_W-1:0];

  // A fresh message shows up while we wait for one
  assign arriving = armed && in_s.val;

  // On the arrival cycle the draw decides, later the counter does
  assign stall = arriving ? (draw != '0) : (cnt != '0);

  // Mask both directions while stalling, otherwise pass straight through
  assign out_s.val = in_s.val && !stall;
  assign out_s.msg = in_s.msg;
  assign in_rdy    = out_rdy && !stall;

  assign xfer = in_s.val && in_rdy;

  // ----------------------------------------
  // LFSR, counter and arm flag
  // ----------------------------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      lfsr  <= SEED;
      cnt   <= '0;
      armed <= 1'b1;
    end
    else
    begin
      if (arriving)
      begin
        // One LFSR step per draw
        lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? LFSR_TAPS : 16'h0000);
        // Arrival cycle already counts as the first stall cycle
        if (draw != '0)
          cnt <= draw - 1'b1;
      end
      else if (cnt != '0)
        cnt <= cnt - 1'b1;

      // Re-arm once the message has gone through
      if (xfer)
        armed <= 1'b1;
      else if (arriving)
        armed <= 1'b0;
    end
  end

endmodule

/* hdl/stream_test_pkg.sv */
// ----------------------------------------
// Shared types for the stream test harness
// Import with a wildcard in the module header
// ----------------------------------------

`include "stream_test_macros.svh"

package stream_test_pkg;

  // ----------------------------------------
  // Stream link
  // ----------------------------------------

  // Forward half of a valid/ready link
  // Ready travels the other way as a plain bit
  typedef struct packed {
    logic              val;
    logic [`MSG_W-1:0] msg;
  } stream_t;

  // ----------------------------------------
  // Memory load port
  // ----------------------------------------

  // One write into the source or sink memory
  // sel = 0 picks the source memory, sel = 1 the sink memory
  typedef struct packed {
    logic              we;
    logic              sel;
    logic [`IDX_W-1:0] addr;
    logic [`MSG_W-1:0] data;
  } load_t;

  // Memory select encodings
  localparam logic SEL_SRC  = 1'b0;
  localparam logic SEL_SINK = 1'b1;

endpackage

/* hdl/stream_test_macros.svh */
// ----------------------------------------
// Width and depth settings for the stream test harness
// Include before any package or module that sizes ports or memories
// ----------------------------------------

`ifndef STREAM_TEST_MACROS_SVH
`define STREAM_TEST_MACROS_SVH

// Message payload width in bits
`define MSG_W 8

// Entries in each of the source and sink memories
`define MEM_DEPTH 64

// Memory index and message count width
// One bit wider than the address so a full count of 64 fits
`define IDX_W 7

// Maximum random stall per delay stage
`define DELAY_W 8

`endif
